/* design/core_pkg.sv */
package core_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int INST_ADDR_WIDTH = 7;
	localparam int INST_MEM_DEPTH = 1 << INST_ADDR_WIDTH;
	localparam int DATA_WIDTH = 32;
	localparam int OPERAND_WIDTH = 15;

	// issue edge to bus, in cycles
	localparam int ADD_LATENCY = 1;
	localparam int MUL_LATENCY = 3;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	typedef enum logic {
		LOAD,
		EXEC
	} mode_t;

	typedef enum logic {
		UNIT_ADD_SUB,
		UNIT_MUL
	} unit_t;

	// one instruction word, msb first
	typedef struct packed {
		unit_t unit;
		logic sub;
		logic [OPERAND_WIDTH-1:0] op_a;
		logic [OPERAND_WIDTH-1:0] op_b;
	} inst_t;

endpackage

/* design/mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic sw_w,
	input  logic sw_e,
	output core_pkg::mode_t mode,
	output logic mode_change,
	output logic exec
);
	logic sw_w_q;
	logic sw_e_q;
	core_pkg::mode_t next_mode;

	// load wins when both switches are on
	always_comb begin
		if (sw_w_q)
			next_mode = core_pkg::LOAD;
		else if (sw_e_q)
			next_mode = core_pkg::EXEC;
		else
			next_mode = mode;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_w_q <= 1'b0;
			sw_e_q <= 1'b0;
			mode <= core_pkg::LOAD;
			mode_change <= 1'b0;
		end else begin
			sw_w_q <= sw_w;
			sw_e_q <= sw_e;
			mode <= next_mode;
			mode_change <= next_mode != mode;
		end
	end

	// first exec cycle is spent fetching word 0
	assign exec = (mode == core_pkg::EXEC) && !mode_change;

endmodule

/* design/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch (
	input  logic clk,
	input  logic rst_n,
	input  core_pkg::mode_t mode,
	input  logic mode_change,
	input  logic exec,
	input  logic stall,
	input  logic load_valid,
	input  logic [$bits(core_pkg::inst_t)-1:0] load_data,
	output core_pkg::inst_t inst,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] inst_addr,
	output logic inst_valid,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] pc
);
	core_pkg::inst_t mem [core_pkg::INST_MEM_DEPTH];
	logic [core_pkg::INST_ADDR_WIDTH-1:0] len;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] base;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] pc_next;
	logic load_we;

	// pc restarts from 0 in the first cycle of either mode
	assign base = mode_change ? '0 : pc;
	assign load_we = (mode == core_pkg::LOAD) && load_valid;
	assign inst_valid = exec && (pc < len);

	always_comb begin
		if (load_we || (inst_valid && !stall))
			pc_next = base + 1'b1;
		else
			pc_next = base;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			len <= '0;
		end else begin
			pc <= pc_next;
			// number of words loaded so far
			if (mode_change && mode == core_pkg::EXEC)
				len <= pc;
		end
	end

	////////////////////////////////////////
	// memory
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load_we)
			mem[base] <= core_pkg::inst_t'(load_data);
		if (!stall)
			inst <= mem[pc_next];
	end

	// register holds the word at pc
	assign inst_addr = pc;

	a_pc_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		exec |-> pc <= len);

endmodule

/* design/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
	input  core_pkg::inst_t inst,
	input  logic [core_pkg::INST_ADDR_WIDTH-1:0] inst_addr,
	input  logic inst_valid,
	input  logic add_ready,
	output logic add_start,
	output logic mul_start,
	output logic sub,
	output logic [core_pkg::DATA_WIDTH-1:0] op_a,
	output logic [core_pkg::DATA_WIDTH-1:0] op_b,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] issue_tag,
	output logic stall
);
	localparam int PAD_WIDTH = core_pkg::DATA_WIDTH - core_pkg::OPERAND_WIDTH;

	logic is_mul;

	assign is_mul = inst.unit == core_pkg::UNIT_MUL;

	// multiply owns the deepest slot, never refused
	assign mul_start = inst_valid && is_mul;

	// add waits for its slot
	assign add_start = inst_valid && !is_mul && add_ready;
	assign stall = inst_valid && !is_mul && !add_ready;

	////////////////////////////////////////
	// operands
	////////////////////////////////////////

	assign sub = inst.sub;
	assign op_a = {{PAD_WIDTH{1'b0}}, inst.op_a};
	assign op_b = {{PAD_WIDTH{1'b0}}, inst.op_b};

	// tag is the instruction address
	assign issue_tag = inst_addr;

endmodule

/* design/add_sub_unit.sv */
`timescale 1ns/1ps

module add_sub_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic add_start,
	input  logic sub,
	input  logic [core_pkg::DATA_WIDTH-1:0] op_a,
	input  logic [core_pkg::DATA_WIDTH-1:0] op_b,
	input  logic [core_pkg::INST_ADDR_WIDTH-1:0] issue_tag,
	output logic [core_pkg::DATA_WIDTH-1:0] add_result,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] add_tag
);
	logic [core_pkg::DATA_WIDTH-1:0] sum;

	// wraps modulo 2^32
	always_comb begin
		if (sub)
			sum = op_a - op_b;
		else
			sum = op_a + op_b;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			add_result <= '0;
			add_tag <= '0;
		end else if (add_start) begin
			add_result <= sum;
			add_tag <= issue_tag;
		end
	end

endmodule

/* design/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic mul_start,
	input  logic [core_pkg::DATA_WIDTH-1:0] op_a,
	input  logic [core_pkg::DATA_WIDTH-1:0] op_b,
	input  logic [core_pkg::INST_ADDR_WIDTH-1:0] issue_tag,
	output logic [core_pkg::DATA_WIDTH-1:0] mul_result,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] mul_tag
);
	logic [core_pkg::DATA_WIDTH-1:0] a_q;
	logic [core_pkg::DATA_WIDTH-1:0] b_q;
	logic [core_pkg::DATA_WIDTH-1:0] prod_q;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] tag_s1;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] tag_s2;

	////////////////////////////////////////
	// three stages, one issue per cycle
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (mul_start) begin
			a_q <= op_a;
			b_q <= op_b;
		end
		// low word of the product only
		prod_q <= a_q * b_q;
		mul_result <= prod_q;
	end

	// tags ride along with the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_s1 <= '0;
			tag_s2 <= '0;
			mul_tag <= '0;
		end else begin
			if (mul_start)
				tag_s1 <= issue_tag;
			tag_s2 <= tag_s1;
			mul_tag <= tag_s2;
		end
	end

endmodule

/* design/result_bus.sv */
`timescale 1ns/1ps

module result_bus (
	input  logic clk,
	input  logic rst_n,
	input  logic add_start,
	input  logic mul_start,
	input  logic [core_pkg::DATA_WIDTH-1:0] add_result,
	input  logic [core_pkg::INST_ADDR_WIDTH-1:0] add_tag,
	input  logic [core_pkg::DATA_WIDTH-1:0] mul_result,
	input  logic [core_pkg::INST_ADDR_WIDTH-1:0] mul_tag,
	output logic add_ready,
	output logic cdb_valid,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] cdb_tag,
	output logic [core_pkg::DATA_WIDTH-1:0] cdb_data
);
	localparam int DEPTH = core_pkg::MUL_LATENCY;
	localparam int ADD_SLOT = core_pkg::ADD_LATENCY - 1;

	// slot 0 goes to the bus on the next edge
	logic [DEPTH-1:0] slot_valid;
	core_pkg::unit_t slot_src [DEPTH];

	// the slot above would shift into the add slot
	assign add_ready = !slot_valid[ADD_SLOT + 1];

	////////////////////////////////////////
	// reservation shift register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				if (i == ADD_SLOT)
					slot_valid[i] <= slot_valid[i + 1] || add_start;
				else
					slot_valid[i] <= slot_valid[i + 1];
			end
			slot_valid[DEPTH - 1] <= mul_start;
		end
	end

	// source is recorded by whichever unit fills the slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH - 1; i++) begin
			if (i == ADD_SLOT && add_start)
				slot_src[i] <= core_pkg::UNIT_ADD_SUB;
			else
				slot_src[i] <= slot_src[i + 1];
		end
		slot_src[DEPTH - 1] <= mul_start ? core_pkg::UNIT_MUL : core_pkg::UNIT_ADD_SUB;
	end

	////////////////////////////////////////
	// bus output
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= slot_valid[0];
	end

	always_ff @(posedge clk) begin
		if (slot_src[0] == core_pkg::UNIT_MUL) begin
			cdb_tag <= mul_tag;
			cdb_data <= mul_result;
		end else begin
			cdb_tag <= add_tag;
			cdb_data <= add_result;
		end
	end

	a_add_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
		add_start |-> !slot_valid[ADD_SLOT + 1]);

endmodule

/* design/core.sv */
`timescale 1ns/1ps

module core (
	input  logic clk,
	input  logic rst_n,
	input  logic sw_w,
	input  logic sw_e,
	input  logic load_valid,
	input  logic [31:0] load_data,
	output logic cdb_valid,
	output logic [core_pkg::INST_ADDR_WIDTH-1:0] cdb_tag,
	output logic [core_pkg::DATA_WIDTH-1:0] cdb_data,
	output logic [7:0] led
);
	core_pkg::mode_t mode;
	logic mode_change;
	logic exec;

	core_pkg::inst_t inst;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] inst_addr;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] pc;
	logic inst_valid;
	logic stall;

	logic add_start;
	logic mul_start;
	logic add_ready;
	logic sub;
	logic [core_pkg::DATA_WIDTH-1:0] op_a;
	logic [core_pkg::DATA_WIDTH-1:0] op_b;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] issue_tag;

	logic [core_pkg::DATA_WIDTH-1:0] add_result;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] add_tag;
	logic [core_pkg::DATA_WIDTH-1:0] mul_result;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] mul_tag;

	// status
	assign led[7] = mode == core_pkg::EXEC;
	assign led[6:0] = pc;

	mode_ctrl u_mode_ctrl (
		.clk, .rst_n, .sw_w, .sw_e,
		.mode, .mode_change, .exec
	);

	inst_fetch u_inst_fetch (
		.clk, .rst_n, .mode, .mode_change, .exec, .stall,
		.load_valid, .load_data,
		.inst, .inst_addr, .inst_valid, .pc
	);

	issue_ctrl u_issue_ctrl (
		.inst, .inst_addr, .inst_valid, .add_ready,
		.add_start, .mul_start, .sub, .op_a, .op_b, .issue_tag, .stall
	);

	add_sub_unit u_add_sub_unit (
		.clk, .rst_n, .add_start, .sub, .op_a, .op_b, .issue_tag,
		.add_result, .add_tag
	);

	mul_unit u_mul_unit (
		.clk, .rst_n, .mul_start, .op_a, .op_b, .issue_tag,
		.mul_result, .mul_tag
	);

	result_bus u_result_bus (
		.clk, .rst_n, .add_start, .mul_start,
		.add_result, .add_tag, .mul_result, .mul_tag,
		.add_ready, .cdb_valid, .cdb_tag, .cdb_data
	);

endmodule

/* testbench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

	localparam int WAIT_LIMIT = 2000;
	localparam int DEPTH = core_pkg::INST_MEM_DEPTH;

	logic clk;
	logic rst_n;
	logic sw_w;
	logic sw_e;
	logic load_valid;
	logic [31:0] load_data;
	logic cdb_valid;
	logic [core_pkg::INST_ADDR_WIDTH-1:0] cdb_tag;
	logic [core_pkg::DATA_WIDTH-1:0] cdb_data;
	logic [7:0] led;

	logic [31:0] prog [DEPTH];
	int seen_count [DEPTH];
	logic [31:0] seen_data [DEPTH];
	int quiet_cycles;
	int errors;
	logic [31:0] rnd_state;

	core dut (
		.clk, .rst_n, .sw_w, .sw_e, .load_valid, .load_data,
		.cdb_valid, .cdb_tag, .cdb_data, .led
	);

	always #20 clk = ~clk;

	// bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && cdb_valid) begin
			seen_count[cdb_tag] = seen_count[cdb_tag] + 1;
			seen_data[cdb_tag] = cdb_data;
			quiet_cycles = 0;
		end else begin
			quiet_cycles = quiet_cycles + 1;
		end
	end

	////////////////////////////////////////
	// helpers and model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] make_inst(input logic mul, input logic sub,
		input logic [14:0] a, input logic [14:0] b);
		return {mul, sub, a, b};
	endfunction

	// unit in bit 31, sub in bit 30, then a and b unsigned
	function automatic logic [31:0] expected_result(input logic [31:0] word);
		logic [31:0] a;
		logic [31:0] b;
		a = {17'd0, word[29:15]};
		b = {17'd0, word[14:0]};
		if (word[31])
			return a * b;
		else if (word[30])
			return a - b;
		else
			return a + b;
	endfunction

	task automatic check_eq(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s: %s expected %h actual %h", name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic clear_scoreboard();
		for (int i = 0; i < DEPTH; i++) begin
			seen_count[i] = 0;
			seen_data[i] = '0;
		end
	endtask

	task automatic do_reset();
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_mode(input string name, input logic exec_on);
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (led[7] !== exec_on && t < WAIT_LIMIT);
		if (led[7] !== exec_on) begin
			$display("%s: timed out waiting for the mode LED to change", name);
			errors++;
		end
	endtask

	task automatic wait_pc(input string name, input int n);
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (led[6:0] !== 7'(n) && t < WAIT_LIMIT);
		if (led[6:0] !== 7'(n)) begin
			$display("%s: timed out waiting for the program counter to reach %0d", name, n);
			errors++;
		end
	endtask

	// no bus result for a full multiply latency
	task automatic wait_quiet(input string name);
		int t;
		t = 0;
		@(posedge clk);
		quiet_cycles = 0;
		do begin
			@(posedge clk);
			t++;
		end while (quiet_cycles < core_pkg::MUL_LATENCY && t < WAIT_LIMIT);
		if (quiet_cycles < core_pkg::MUL_LATENCY) begin
			$display("%s: timed out waiting for the result bus to go quiet", name);
			errors++;
		end
	endtask

	task automatic load_program(input string name, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			load_valid <= 1'b1;
			load_data <= prog[i];
		end
		@(posedge clk);
		load_valid <= 1'b0;
		load_data <= '0;
		@(negedge clk);
		check_eq(name, "led after load", {24'd0, 1'b0, 7'(n)}, {24'd0, led});
	endtask

	task automatic enter_load(input string name);
		@(posedge clk);
		sw_e <= 1'b0;
		sw_w <= 1'b1;
		wait_mode(name, 1'b0);
		// pc clears one cycle after the switch
		@(negedge clk);
		check_eq(name, "led in load", 32'd0, {24'd0, led});
	endtask

	task automatic run_exec(input string name, input int n);
		@(posedge clk);
		clear_scoreboard();
		sw_w <= 1'b0;
		sw_e <= 1'b1;
		wait_mode(name, 1'b1);
		// first exec cycle still shows the load count
		@(negedge clk);
		wait_pc(name, n);
		wait_quiet(name);
		check_eq(name, "led after run", {24'd0, 1'b1, 7'(n)}, {24'd0, led});
	endtask

	task automatic check_results(input string name, input int n);
		for (int i = 0; i < DEPTH; i++) begin
			if (i < n) begin
				check_eq(name, $sformatf("tag %0d count", i), 32'd1, seen_count[i]);
				if (seen_count[i] == 1)
					check_eq(name, $sformatf("tag %0d data", i),
						expected_result(prog[i]), seen_data[i]);
			end else begin
				check_eq(name, $sformatf("tag %0d count", i), 32'd0, seen_count[i]);
			end
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic after_reset_quiet();
		repeat (10) begin
			@(negedge clk);
			check_eq("after_reset", "led", 32'd0, {24'd0, led});
			check_eq("after_reset", "cdb_valid", 32'd0, {31'd0, cdb_valid});
		end
	endtask

	task automatic add_sub_program();
		for (int i = 0; i < 12; i++)
			prog[i] = make_inst(1'b0, i[0], 15'(i * 2711 + 13), 15'(30000 - i * 1500));
		load_program("add_sub", 12);
		run_exec("add_sub", 12);
		check_results("add_sub", 12);
	endtask

	// multiply then adds forces the add slot to collide
	task automatic mixed_program();
		enter_load("mixed");
		prog[0] = make_inst(1'b1, 1'b0, 15'd3, 15'd5);
		prog[1] = make_inst(1'b0, 1'b0, 15'd100, 15'd23);
		prog[2] = make_inst(1'b0, 1'b1, 15'd50, 15'd70);
		prog[3] = make_inst(1'b0, 1'b0, 15'h7fff, 15'h7fff);
		prog[4] = make_inst(1'b1, 1'b0, 15'h7fff, 15'h7fff);
		prog[5] = make_inst(1'b1, 1'b1, 15'd1234, 15'd4);
		prog[6] = make_inst(1'b1, 1'b0, 15'd0, 15'd999);
		prog[7] = make_inst(1'b0, 1'b0, 15'd1, 15'd1);
		prog[8] = make_inst(1'b0, 1'b1, 15'd0, 15'h7fff);
		prog[9] = make_inst(1'b1, 1'b0, 15'd300, 15'd200);
		prog[10] = make_inst(1'b0, 1'b0, 15'd5, 15'd6);
		prog[11] = make_inst(1'b0, 1'b0, 15'd9, 15'd9);
		prog[12] = make_inst(1'b1, 1'b0, 15'd2, 15'd2);
		prog[13] = make_inst(1'b0, 1'b0, 15'd0, 15'd0);
		load_program("mixed", 14);
		run_exec("mixed", 14);
		check_results("mixed", 14);
	endtask

	task automatic random_program();
		int n;
		enter_load("random");
		rnd_state = xorshift32(rnd_state);
		n = 16 + int'(rnd_state % 40);
		for (int i = 0; i < n; i++) begin
			rnd_state = xorshift32(rnd_state);
			prog[i] = rnd_state;
		end
		load_program("random", n);
		run_exec("random", n);
		check_results("random", n);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		sw_w = 1'b0;
		sw_e = 1'b0;
		load_valid = 1'b0;
		load_data = '0;
		errors = 0;
		quiet_cycles = 0;
		rnd_state = 32'h21e9_6e24;
		clear_scoreboard();

		do_reset();
		after_reset_quiet();
		add_sub_program();
		mixed_program();
		random_program();

		$display("errors %0d", errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* core.f */
design/core_pkg.sv
design/mode_ctrl.sv
design/inst_fetch.sv
design/issue_ctrl.sv
design/add_sub_unit.sv
design/mul_unit.sv
design/result_bus.sv
design/core.sv
testbench/core_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f core.f --top-module core_tb -o core_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
fi
exit 1
